// File: src/turbo_pkg.sv
package turbo_pkg;

	//////////////////////////////
	// widths and block sizes
	//////////////////////////////

	localparam int metric_w = 16;
	localparam int num_states = 8;
	localparam int tail_len = 4;
	localparam int max_blklen = 60;
	localparam int max_steps = max_blklen + tail_len;
	localparam int step_w = $clog2(max_steps);

	// llr or state metric, wraps at 16 bits
	typedef logic signed [metric_w-1:0] metric_t;
	// one metric per trellis state
	typedef metric_t [num_states-1:0] metric_vec_t;
	typedef logic [step_w-1:0] step_idx_t;
	typedef logic [step_w-1:0] blk_len_t;

	// initial beta of states 1 to 7
	localparam metric_t beta_floor = -16'sd128;

	//////////////////////////////
	// trellis connectivity
	//////////////////////////////

	// partner state taken with the branch added
	localparam int trellis_succ_add [num_states] = '{0, 4, 5, 1, 2, 6, 7, 3};
	// partner state taken with the branch subtracted
	localparam int trellis_succ_sub [num_states] = '{4, 0, 1, 5, 6, 2, 3, 7};
	// states 2..5 use g2, the others g1
	localparam logic [num_states-1:0] branch_is_g2 = 8'b0011_1100;

	// one memory word per trellis step
	typedef struct packed {
		metric_t     branch1;
		metric_t     branch2;
		metric_t     sys;
		metric_t     apriori;
		metric_vec_t alpha;
		metric_vec_t beta;
	} step_word_t;

	// part of a word updated by a write
	typedef enum logic {FIELD_INPUT, FIELD_BETA} mem_field_e;

	// arbiter ports, lowest value wins
	typedef enum logic [1:0] {LOADER, BETA, LLR} engine_e;

	// signed max of two metrics
	function automatic metric_t metric_max(metric_t a, metric_t b);
		return (a > b) ? a : b;
	endfunction

endpackage

// File: src/step_mem_if.sv
`timescale 1ns/100ps

interface step_mem_if import turbo_pkg::*; ();

	// request and grant levels
	logic       req;
	logic       gnt;
	// access fields, sampled when req and gnt are both high
	logic       we;
	mem_field_e field;
	step_idx_t  addr;
	step_word_t wdata;
	// valid one cycle after a granted read
	step_word_t rdata;

	modport requester (
		output req,
		output we,
		output field,
		output addr,
		output wdata,
		input  gnt,
		input  rdata
	);

	modport memory (
		input  req,
		input  we,
		input  field,
		input  addr,
		input  wdata,
		output gnt,
		output rdata
	);

endinterface

// File: src/step_mem_arbiter.sv
`timescale 1ns/100ps

module step_mem_arbiter import turbo_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	step_mem_if.memory    loader_port,
	step_mem_if.memory    beta_port,
	step_mem_if.memory    llr_port
);

	logic [2:0] req;
	engine_e    owner_q;
	logic       owned_q;
	engine_e    sel;
	logic       acc;

	// selected port fields
	logic       we_sel;
	mem_field_e field_sel;
	step_idx_t  addr_sel;
	step_word_t wdata_sel;

	step_word_t mem_q [max_steps];
	step_word_t rdata_q;

	assign req[LOADER] = loader_port.req;
	assign req[BETA]   = beta_port.req;
	assign req[LLR]    = llr_port.req;

	//////////////////////////////
	// grant
	//////////////////////////////

	// owner keeps the grant while its req stays high
	always_comb begin
		sel = owner_q;
		acc = 1'b0;
		if (owned_q && req[owner_q]) begin
			acc = 1'b1;
		end else if (req[LOADER]) begin
			sel = LOADER;
			acc = 1'b1;
		end else if (req[BETA]) begin
			sel = BETA;
			acc = 1'b1;
		end else if (req[LLR]) begin
			sel = LLR;
			acc = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			owner_q <= LOADER;
			owned_q <= 1'b0;
		end else begin
			owner_q <= sel;
			owned_q <= acc;
		end
	end

	assign loader_port.gnt = acc && (sel == LOADER);
	assign beta_port.gnt   = acc && (sel == BETA);
	assign llr_port.gnt    = acc && (sel == LLR);

	// mux toward the memory
	always_comb begin
		case (sel)
			BETA: begin
				we_sel    = beta_port.we;
				field_sel = beta_port.field;
				addr_sel  = beta_port.addr;
				wdata_sel = beta_port.wdata;
			end
			LLR: begin
				we_sel    = llr_port.we;
				field_sel = llr_port.field;
				addr_sel  = llr_port.addr;
				wdata_sel = llr_port.wdata;
			end
			default: begin
				we_sel    = loader_port.we;
				field_sel = loader_port.field;
				addr_sel  = loader_port.addr;
				wdata_sel = loader_port.wdata;
			end
		endcase
	end

	//////////////////////////////
	// step memory
	//////////////////////////////

	// input fields and beta field written apart
	always_ff @(posedge clk) begin
		if (acc && we_sel) begin
			if (field_sel == FIELD_BETA) begin
				mem_q[addr_sel].beta <= wdata_sel.beta;
			end else begin
				mem_q[addr_sel].branch1 <= wdata_sel.branch1;
				mem_q[addr_sel].branch2 <= wdata_sel.branch2;
				mem_q[addr_sel].sys     <= wdata_sel.sys;
				mem_q[addr_sel].apriori <= wdata_sel.apriori;
				mem_q[addr_sel].alpha   <= wdata_sel.alpha;
			end
		end
		if (acc && !we_sel)
			rdata_q <= mem_q[addr_sel];
	end

	// shared read bus, each engine knows when its own read lands
	assign loader_port.rdata = rdata_q;
	assign beta_port.rdata   = rdata_q;
	assign llr_port.rdata    = rdata_q;

endmodule

// File: src/block_loader.sv
`timescale 1ns/100ps

module block_loader import turbo_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start_i,
	input  blk_len_t      blklen_i,
	input  logic          in_valid_i,
	input  metric_t       branch1_i,
	input  metric_t       branch2_i,
	input  metric_t       sys_i,
	input  metric_t       apriori_i,
	input  metric_vec_t   alpha_i,
	input  logic          block_done_i,
	step_mem_if.requester mem,
	output logic          load_done_o,
	output step_idx_t     steps_o,
	output blk_len_t      blklen_o,
	output logic          busy_o
);

	typedef enum logic [1:0] {LD_IDLE, LD_LOAD, LD_WAIT} ld_state_e;

	ld_state_e state_q;
	step_idx_t addr_q;
	// address of the last tail step
	step_idx_t last_q;
	blk_len_t  blklen_q;
	logic      step_wr;

	assign mem.req   = (state_q == LD_LOAD);
	assign mem.we    = in_valid_i;
	assign mem.field = FIELD_INPUT;
	assign mem.addr  = addr_q;

	always_comb begin
		mem.wdata         = '0;
		mem.wdata.branch1 = branch1_i;
		mem.wdata.branch2 = branch2_i;
		mem.wdata.sys     = sys_i;
		mem.wdata.apriori = apriori_i;
		mem.wdata.alpha   = alpha_i;
	end

	// step stored this cycle
	assign step_wr = mem.req && mem.gnt && in_valid_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q     <= LD_IDLE;
			addr_q      <= '0;
			load_done_o <= 1'b0;
		end else begin
			load_done_o <= 1'b0;
			case (state_q)
				LD_IDLE: begin
					if (start_i) begin
						addr_q  <= '0;
						state_q <= LD_LOAD;
					end
				end
				LD_LOAD: begin
					if (step_wr) begin
						if (addr_q == last_q) begin
							load_done_o <= 1'b1;
							state_q     <= LD_WAIT;
						end else begin
							addr_q <= addr_q + 1'b1;
						end
					end
				end
				// beta and llr phases
				LD_WAIT: begin
					if (block_done_i)
						state_q <= LD_IDLE;
				end
				default: state_q <= LD_IDLE;
			endcase
		end
	end

	// block size taken at start
	always_ff @(posedge clk) begin
		if (state_q == LD_IDLE && start_i) begin
			blklen_q <= blklen_i;
			last_q   <= blklen_i + step_idx_t'(tail_len - 1);
		end
	end

	assign busy_o   = (state_q != LD_IDLE);
	assign steps_o  = last_q;
	assign blklen_o = blklen_q;

endmodule

// File: src/beta_engine.sv
`timescale 1ns/100ps

module beta_engine import turbo_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start_i,
	// index of the last tail step
	input  step_idx_t     steps_i,
	step_mem_if.requester mem,
	output logic          done_o
);

	// read the branch pair, then write back and update
	typedef enum logic [1:0] {BE_IDLE, BE_READ, BE_UPDATE} be_state_e;

	be_state_e   state_q;
	step_idx_t   step_q;
	// running un-normalized beta(k+1)
	metric_vec_t beta_q;
	metric_vec_t beta_next;
	metric_vec_t beta_norm;

	//////////////////////////////
	// butterflies
	//////////////////////////////

	always_comb begin
		metric_t g;
		metric_t cand_p;
		metric_t cand_m;
		for (int s = 0; s < num_states; s++) begin
			g = branch_is_g2[s] ? mem.rdata.branch2 : mem.rdata.branch1;
			cand_p = beta_q[trellis_succ_add[s]] + g;
			cand_m = beta_q[trellis_succ_sub[s]] - g;
			beta_next[s] = metric_max(cand_p, cand_m);
			// relative to state 0
			beta_norm[s] = beta_q[s] - beta_q[0];
		end
	end

	// req held for the whole walk so the grant stays here
	assign mem.req   = (state_q != BE_IDLE);
	assign mem.we    = (state_q == BE_UPDATE);
	assign mem.field = FIELD_BETA;
	assign mem.addr  = step_q;

	always_comb begin
		mem.wdata      = '0;
		mem.wdata.beta = beta_norm;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= BE_IDLE;
			step_q  <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			case (state_q)
				BE_IDLE: begin
					if (start_i) begin
						step_q  <= steps_i;
						state_q <= BE_READ;
					end
				end
				BE_READ: begin
					if (mem.gnt)
						state_q <= BE_UPDATE;
				end
				// rdata holds step k here
				BE_UPDATE: begin
					if (mem.gnt) begin
						if (step_q == '0) begin
							done_o  <= 1'b1;
							state_q <= BE_IDLE;
						end else begin
							step_q  <= step_q - 1'b1;
							state_q <= BE_READ;
						end
					end
				end
				default: state_q <= BE_IDLE;
			endcase
		end
	end

	// beta(N) seeded for each block
	always_ff @(posedge clk) begin
		if (state_q == BE_IDLE && start_i) begin
			for (int s = 0; s < num_states; s++)
				beta_q[s] <= (s == 0) ? metric_t'(0) : beta_floor;
		end else if (state_q == BE_UPDATE && mem.gnt) begin
			beta_q <= beta_next;
		end
	end

endmodule

// File: src/llr_engine.sv
`timescale 1ns/100ps

module llr_engine import turbo_pkg::*; (
	input  logic          clk,
	input  logic          rst,
	input  logic          start_i,
	input  blk_len_t      blklen_i,
	step_mem_if.requester mem,
	output metric_t       extrinsic_o,
	output logic          extrinsic_valid_o,
	output logic          done_o
);

	typedef enum logic [1:0] {LL_IDLE, LL_RUN, LL_DRAIN} ll_state_e;

	localparam int pipe_len = 7;

	ll_state_e state_q;
	step_idx_t step_q;
	logic      rd_issue;
	// 0 rdata, 1 terms, 2..4 max levels, 5 llr, 6 extrinsic
	logic [pipe_len-1:0] vld_q;

	// index 0 for llr1, 1 for llr2
	metric_t term_q [2][num_states];
	metric_t lvl1_q [2][4];
	metric_t lvl2_q [2][2];
	metric_t lvl3_q [2];
	metric_t llr_q;
	metric_t ext_q;
	// sys + apriori moving with the step
	metric_t sa_q [5];

	assign mem.req   = (state_q == LL_RUN);
	assign mem.we    = 1'b0;
	assign mem.field = FIELD_INPUT;
	assign mem.addr  = step_q;
	assign mem.wdata = '0;

	assign rd_issue = mem.req && mem.gnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= LL_IDLE;
			step_q  <= '0;
			vld_q   <= '0;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			vld_q  <= {vld_q[pipe_len-2:0], rd_issue};
			case (state_q)
				LL_IDLE: begin
					if (start_i) begin
						step_q  <= '0;
						state_q <= LL_RUN;
					end
				end
				// steps 0..blklen-1, forward order
				LL_RUN: begin
					if (rd_issue) begin
						if (step_q == blklen_i - 1'b1)
							state_q <= LL_DRAIN;
						else
							step_q <= step_q + 1'b1;
					end
				end
				// last step leaving the output stage
				LL_DRAIN: begin
					if (vld_q[pipe_len-1] && vld_q[pipe_len-2:0] == '0) begin
						done_o  <= 1'b1;
						state_q <= LL_IDLE;
					end
				end
				default: state_q <= LL_IDLE;
			endcase
		end
	end

	//////////////////////////////
	// datapath, moves every cycle
	//////////////////////////////

	always_ff @(posedge clk) begin
		metric_t g;
		for (int s = 0; s < num_states; s++) begin
			g = branch_is_g2[s] ? mem.rdata.branch2 : mem.rdata.branch1;
			term_q[0][s] <= mem.rdata.alpha[s] - g + mem.rdata.beta[trellis_succ_sub[s]];
			term_q[1][s] <= mem.rdata.alpha[s] + g + mem.rdata.beta[trellis_succ_add[s]];
		end
		sa_q[0] <= mem.rdata.sys + mem.rdata.apriori;
		for (int i = 1; i < 5; i++)
			sa_q[i] <= sa_q[i-1];

		// max trees, 8 to 4 to 2 to 1
		for (int t = 0; t < 2; t++) begin
			for (int i = 0; i < 4; i++)
				lvl1_q[t][i] <= metric_max(term_q[t][2*i], term_q[t][2*i+1]);
			for (int i = 0; i < 2; i++)
				lvl2_q[t][i] <= metric_max(lvl1_q[t][2*i], lvl1_q[t][2*i+1]);
			lvl3_q[t] <= metric_max(lvl2_q[t][0], lvl2_q[t][1]);
		end

		llr_q <= lvl3_q[0] - lvl3_q[1];
		// twice llr minus sys and apriori
		ext_q <= (llr_q - sa_q[4]) <<< 1;
	end

	assign extrinsic_o       = ext_q;
	assign extrinsic_valid_o = vld_q[pipe_len-1];

endmodule

// File: src/siso_beta_llr.sv
`timescale 1ns/100ps

module siso_beta_llr import turbo_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        start_i,
	input  blk_len_t    blklen_i,
	input  logic        in_valid_i,
	input  metric_t     branch1_i,
	input  metric_t     branch2_i,
	input  metric_t     sys_i,
	input  metric_t     apriori_i,
	input  metric_vec_t alpha_i,
	output metric_t     extrinsic_o,
	output logic        extrinsic_valid_o,
	output logic        busy_o
);

	logic      load_done;
	logic      beta_done;
	logic      block_done;
	step_idx_t steps;
	blk_len_t  blklen_q;

	// one port per engine
	step_mem_if loader_mem ();
	step_mem_if beta_mem ();
	step_mem_if llr_mem ();

	step_mem_arbiter i_arbiter (
		.clk         (clk),
		.rst         (rst),
		.loader_port (loader_mem.memory),
		.beta_port   (beta_mem.memory),
		.llr_port    (llr_mem.memory)
	);

	//////////////////////////////
	// loader, then beta, then llr
	//////////////////////////////

	block_loader i_loader (
		.clk          (clk),
		.rst          (rst),
		.start_i      (start_i),
		.blklen_i     (blklen_i),
		.in_valid_i   (in_valid_i),
		.branch1_i    (branch1_i),
		.branch2_i    (branch2_i),
		.sys_i        (sys_i),
		.apriori_i    (apriori_i),
		.alpha_i      (alpha_i),
		.block_done_i (block_done),
		.mem          (loader_mem.requester),
		.load_done_o  (load_done),
		.steps_o      (steps),
		.blklen_o     (blklen_q),
		.busy_o       (busy_o)
	);

	beta_engine i_beta (
		.clk     (clk),
		.rst     (rst),
		.start_i (load_done),
		.steps_i (steps),
		.mem     (beta_mem.requester),
		.done_o  (beta_done)
	);

	llr_engine i_llr (
		.clk               (clk),
		.rst               (rst),
		.start_i           (beta_done),
		.blklen_i          (blklen_q),
		.mem               (llr_mem.requester),
		.extrinsic_o       (extrinsic_o),
		.extrinsic_valid_o (extrinsic_valid_o),
		.done_o            (block_done)
	);

endmodule

// File: bench/siso_assertions.sv
`timescale 1ns/100ps

module siso_assertions (
	input logic       clk,
	input logic       rst,
	// bit order follows engine_e
	input logic [2:0] req,
	input logic [2:0] gnt,
	input logic [2:0] we,
	input logic       acc,
	input logic       we_sel
);

	// failed assertion count
	int fail_count = 0;

	// never two owners of the memory
	property one_grant_p;
		@(posedge clk) disable iff (rst) $onehot0(gnt);
	endproperty

	// grant only toward a port that asks
	property grant_needs_req_p;
		@(posedge clk) disable iff (rst) (gnt & ~req) == 3'b000;
	endproperty

	// memory write only from the granted port that asks to write
	property write_needs_grant_p;
		@(posedge clk) disable iff (rst) (acc && we_sel) |-> ((gnt & req & we) != 3'b000);
	endproperty

	one_grant_a: assert property (one_grant_p)
		else begin
			fail_count++;
			$error("more than one arbiter grant in the same cycle");
		end
	grant_needs_req_a: assert property (grant_needs_req_p)
		else begin
			fail_count++;
			$error("arbiter grant given to a port without request");
		end
	write_needs_grant_a: assert property (write_needs_grant_p)
		else begin
			fail_count++;
			$error("step memory written without a grant");
		end

endmodule

bind step_mem_arbiter siso_assertions i_siso_assertions (
	.clk    (clk),
	.rst    (rst),
	.req    (req),
	.gnt    ({llr_port.gnt, beta_port.gnt, loader_port.gnt}),
	.we     ({llr_port.we, beta_port.we, loader_port.we}),
	.acc    (acc),
	.we_sel (we_sel)
);

// File: bench/tb_siso.sv
`timescale 1ns/100ps

module tb_siso import turbo_pkg::*; ();

	logic        clk;
	logic        rst;
	logic        start_i;
	blk_len_t    blklen_i;
	logic        in_valid_i;
	metric_t     branch1_i;
	metric_t     branch2_i;
	metric_t     sys_i;
	metric_t     apriori_i;
	metric_vec_t alpha_i;
	metric_t     extrinsic_o;
	logic        extrinsic_valid_o;
	logic        busy_o;

	// one block as read from the file
	metric_t     in_b1 [max_steps];
	metric_t     in_b2 [max_steps];
	metric_t     in_sys [max_steps];
	metric_t     in_apr [max_steps];
	metric_vec_t in_alpha [max_steps];
	int          exp_val [max_blklen];

	int fd;

	siso_beta_llr i_dut (
		.clk               (clk),
		.rst               (rst),
		.start_i           (start_i),
		.blklen_i          (blklen_i),
		.in_valid_i        (in_valid_i),
		.branch1_i         (branch1_i),
		.branch2_i         (branch2_i),
		.sys_i             (sys_i),
		.apriori_i         (apriori_i),
		.alpha_i           (alpha_i),
		.extrinsic_o       (extrinsic_o),
		.extrinsic_valid_o (extrinsic_valid_o),
		.busy_o            (busy_o)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// reporting
	//////////////////////////////

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string test_name, input int expected, input int actual);
		if (expected != actual) begin
			$display("MISMATCH %s: expected %0d, actual %0d", test_name, expected, actual);
			stop_run("value check failed");
		end
	endtask

	// next line that is not blank and not a comment
	task automatic get_line(output string line, output bit ok);
		int r;
		string kind;
		ok = 1'b0;
		line = "";
		while (!ok && !$feof(fd)) begin
			r = $fgets(line, fd);
			kind = "";
			if (r > 0)
				r = $sscanf(line, "%s", kind);
			if (r > 0 && kind.len() > 0 && kind.getc(0) != "#")
				ok = 1'b1;
		end
	endtask

	//////////////////////////////
	// one block through the DUT
	//////////////////////////////

	task automatic run_block(input string name, input int len, input bit spurious);
		int got;
		int idle;
		@(posedge clk);
		start_i  <= 1'b1;
		blklen_i <= blk_len_t'(len);
		for (int k = 0; k < len + tail_len; k++) begin
			@(posedge clk);
			start_i <= 1'b0;
			// random pauses on the input strobe
			while ($urandom_range(0, 3) == 0) begin
				in_valid_i <= 1'b0;
				@(posedge clk);
			end
			// start while busy must be ignored
			if (spurious && k == 2)
				start_i <= 1'b1;
			in_valid_i <= 1'b1;
			branch1_i  <= in_b1[k];
			branch2_i  <= in_b2[k];
			sys_i      <= in_sys[k];
			apriori_i  <= in_apr[k];
			alpha_i    <= in_alpha[k];
		end
		@(posedge clk);
		in_valid_i <= 1'b0;
		start_i    <= 1'b0;

		// outputs sampled away from the active edge
		got = 0;
		idle = 0;
		while (got < len) begin
			@(negedge clk);
			if (extrinsic_valid_o) begin
				check_value(name, exp_val[got], int'(extrinsic_o));
				check_value({name, " busy during output"}, 1, int'(busy_o));
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > 2000)
					stop_run({"timeout: extrinsic values stopped early in ", name});
			end
		end
		idle = 0;
		while (busy_o) begin
			@(negedge clk);
			check_value({name, " extra valid"}, 0, int'(extrinsic_valid_o));
			idle++;
			if (idle > 100)
				stop_run({"timeout: busy_o did not fall after the block ", name});
		end
		repeat (3) begin
			@(negedge clk);
			check_value({name, " valid after done"}, 0, int'(extrinsic_valid_o));
		end
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		string line;
		string name;
		bit    ok;
		int    len;
		int    cnt;
		int    n_in;
		int    n_exp;
		int    n_test;
		int    v [12];
		int    e;
		n_test = 0;
		void'($urandom(32'h2976));
		rst        = 1'b1;
		start_i    = 1'b0;
		blklen_i   = '0;
		in_valid_i = 1'b0;
		branch1_i  = '0;
		branch2_i  = '0;
		sys_i      = '0;
		apriori_i  = '0;
		alpha_i    = '0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// idle after reset
		repeat (6) begin
			@(negedge clk);
			check_value("reset busy_o", 0, int'(busy_o));
			check_value("reset valid", 0, int'(extrinsic_valid_o));
		end

		fd = $fopen("bench/siso_tests.txt", "r");
		if (fd == 0)
			stop_run("could not open bench/siso_tests.txt");

		get_line(line, ok);
		while (ok) begin
			if ($sscanf(line, "test %s %d", name, len) != 2)
				stop_run("test file has a bad test header line");
			if (len < 1 || len > max_blklen)
				stop_run("test file block length out of range");
			n_in = 0;
			while (n_in < len + tail_len) begin
				get_line(line, ok);
				if (!ok || $sscanf(line, "in %d %d %d %d %d %d %d %d %d %d %d %d %d", cnt,
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
						v[10], v[11]) != 13)
					stop_run("test file has a missing or bad input line");
				if (n_in + cnt > len + tail_len)
					stop_run("test file has too many input steps");
				for (int r = 0; r < cnt; r++) begin
					in_b1[n_in]  = metric_t'(v[0]);
					in_b2[n_in]  = metric_t'(v[1]);
					in_sys[n_in] = metric_t'(v[2]);
					in_apr[n_in] = metric_t'(v[3]);
					for (int s = 0; s < num_states; s++)
						in_alpha[n_in][s] = metric_t'(v[4+s]);
					n_in++;
				end
			end
			n_exp = 0;
			while (n_exp < len) begin
				get_line(line, ok);
				if (!ok || $sscanf(line, "exp %d %d", cnt, e) != 2)
					stop_run("test file has a missing or bad expected line");
				if (n_exp + cnt > len)
					stop_run("test file has too many expected values");
				for (int r = 0; r < cnt; r++) begin
					exp_val[n_exp] = e;
					n_exp++;
				end
			end
			run_block(name, len, n_test[0]);
			n_test++;
			get_line(line, ok);
		end
		$fclose(fd);

		if (n_test == 0)
			stop_run("test file holds no test blocks");
		// bound arbiter checks count their own failures
		if (i_dut.i_arbiter.i_siso_assertions.fail_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// File: bench/siso_tests.txt
# test <name> <blklen>, then input lines, then expected lines
# in <repeat> branch1 branch2 sys apriori alpha0..alpha7
# exp <repeat> extrinsic
test short 3
in 1 5 5 3 1 0 -4 7 2 -9 1 0 3
in 1 -2 -2 -6 2 10 3 -5 8 0 1 2 -7
in 1 0 0 7 0 4 4 4 4 4 4 4 4
in 4 0 0 11 -3 6 -2 9 1 0 5 -8 2
exp 1 -28
exp 1 16
exp 1 -14
test max_len 60
in 30 3 3 -1 2 1 2 3 4 5 6 7 8
in 30 -7 -7 4 -5 -20 15 0 9 -3 2 11 -6
in 4 0 0 9 9 1 -1 2 -2 3 -3 4 -4
exp 30 -14
exp 30 30
test wrap 2
in 1 8000 8000 1000 0 3 -2 1 0 5 -1 2 4
in 1 -100 -100 -30 10 0 0 0 0 0 0 0 0
in 4 0 0 0 0 0 0 0 0 0 0 0 0
exp 1 31536
exp 1 440
test single 1
in 1 1 1 0 0 50 50 50 50 50 50 50 50
in 4 0 0 -5 5 7 7 7 7 7 7 7 7
exp 1 -4
test mid 5
in 2 4 4 -2 -2 0 1 0 1 0 1 0 1
in 3 -6 -6 1 3 -3 -3 8 8 -3 -3 2 2
in 4 0 0 2 2 2 2 2 2 2 2 2 2
exp 2 -8
exp 3 16

// File: list.f
src/turbo_pkg.sv
src/step_mem_if.sv
src/step_mem_arbiter.sv
src/block_loader.sv
src/beta_engine.sv
src/llr_engine.sv
src/siso_beta_llr.sv
bench/siso_assertions.sv
bench/tb_siso.sv

// File: Bender.yml
package:
  name: siso_beta_llr

sources:
  - src/turbo_pkg.sv
  - src/step_mem_if.sv
  - src/step_mem_arbiter.sv
  - src/block_loader.sv
  - src/beta_engine.sv
  - src/llr_engine.sv
  - src/siso_beta_llr.sv
  - target: simulation
    files:
      - bench/siso_assertions.sv
      - bench/tb_siso.sv
